// ==== project.f ====
fetch_pkg.sv
fetch_ifs.sv
fetch_target_queue.sv
icache_array.sv
inst_predecode.sv
slot_compactor.sv
fetch_pipeline.sv
fetcher_top.sv
fetcher_properties.sv
tb_fetcher.sv

// ==== run_sim.sh ====
#!/bin/sh
# compile and run the fetcher testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_fetcher \
    -f project.f --Mdir obj_dir -o sim_fetcher
if [ $? -ne 0 ]; then
    echo "verilator compile failed"
    exit 1
fi

./obj_dir/sim_fetcher > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q ">>> FAIL" sim.log; then
    exit 1
fi
if ! grep -q ">>> PASS" sim.log; then
    echo "simulation ended without a result line"
    exit 1
fi
exit 0

// ==== tb_fetcher.sv ====
`timescale 1ns/100ps

module tb_fetcher;

    localparam int PHASES         = 12;
    localparam int PHASE_MAX      = 64;
    localparam int PLANNED_BLOCKS = PHASES * PHASE_MAX;
    localparam int CYCLE_LIMIT    = 20 * fetch_pkg::SLOT_NUM * PLANNED_BLOCKS;

    logic                                              clk;
    logic                                              rst;
    logic                                              i_redirect_vld;
    logic [31:0]                                       i_redirect_pc;
    logic                                              i_backend_stall;
    logic                                              i_commit_vld;
    fetch_pkg::ftq_idx_t                               i_commit_ftq_idx;
    fetch_pkg::ftq_idx_t                               i_read_ftq_idx;
    logic [31:0]                                       o_read_start_addr;
    logic                                              i_imem_wr_vld;
    fetch_pkg::imem_waddr_t                            i_imem_wr_addr;
    logic [31:0]                                       i_imem_wr_data;
    logic [fetch_pkg::SLOT_NUM-1:0]                    o_fetch_vld;
    fetch_pkg::fetch_entry_t [fetch_pkg::SLOT_NUM-1:0] o_fetch_inst;

    // model state
    logic [31:0]         shadow [fetch_pkg::IMEM_WORDS];
    logic [31:0]         exp_q [$];
    fetch_pkg::ftq_idx_t exp_idx;
    fetch_pkg::ftq_idx_t commit_idx_q [$];
    int                  commit_due_q [$];
    logic [7:0]          want_vld;
    logic [31:0]         want_inst [fetch_pkg::SLOT_NUM];
    logic [3:0]          want_off [fetch_pkg::SLOT_NUM];
    logic                want_exc;
    logic                stall_en;
    logic                commit_en;
    int                  beats_since;
    int                  beat_total;
    int                  cycle_cnt;
    int                  timeout_cnt;
    int                  err_cnt;
    int                  chk_cnt;
    integer              seed;
    logic [31:0]         rnd;
    logic                read_pend;
    logic [31:0]         read_exp;

    fetcher_top i_fetcher_top (.*);

    always #5 clk = ~clk;

    always @(posedge clk) begin
        timeout_cnt <= timeout_cnt + 1;
        if (timeout_cnt >= CYCLE_LIMIT) begin
            $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("checks: %0d  errors: %0d  beats: %0d", chk_cnt, err_cnt, beat_total);
            $display(">>> FAIL");
            $finish;
        end
    end

    task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
        chk_cnt++;
        if (got !== exp) begin
            err_cnt++;
            $display("** Error at %0t: %s = %h, expected %h", $time, name, got, exp);
        end
    endtask

    function automatic logic [7:0] byte_at(input logic [31:0] a);
        logic [31:0] w;
        w = shadow[a[9:2]];
        return w[{a[1:0], 3'b000} +: 8];
    endfunction

    // boundary scan from slot 0 of the block, then compaction
    task automatic predict(input logic [31:0] addr);
        logic [31:0] a;
        logic [15:0] half;
        logic        start;
        logic        rvi;
        int          pos;
        want_vld = '0;
        want_exc = addr[0];
        pos      = 0;
        rvi      = 1'b0;
        for (int k = 0; k < fetch_pkg::SLOT_NUM; k++) begin
            want_inst[k] = '0;
            want_off[k]  = '0;
        end
        if (addr[0]) begin
            want_vld = 8'h01;
        end else begin
            for (int k = 0; k < fetch_pkg::SLOT_NUM; k++) begin
                a     = addr + 32'(2 * k);
                start = (k == 0) || !rvi;
                half  = {byte_at(a + 32'd1), byte_at(a)};
                rvi   = start && (half[1:0] == 2'b11);
                if (start) begin
                    want_vld[pos]  = 1'b1;
                    want_inst[pos] = {byte_at(a + 32'd3), byte_at(a + 32'd2),
                                      byte_at(a + 32'd1), byte_at(a)};
                    want_off[pos]  = 4'(2 * k);
                    pos++;
                end
            end
        end
    endtask

    // inputs still hold what the last rising edge sampled
    task automatic observe();
        logic [31:0] addr;
        if (!rst && !i_redirect_vld && !i_backend_stall && o_fetch_vld != '0) begin
            if (exp_q.size() == 0) begin
                err_cnt++;
                $display("unexpected output beat at %0t with no block left in the model", $time);
            end else begin
                addr = exp_q.pop_front();
                predict(addr);
                compare("o_fetch_vld", 32'(o_fetch_vld), 32'(want_vld));
                for (int k = 0; k < fetch_pkg::SLOT_NUM; k++) begin
                    if (want_vld[k]) begin
                        if (!want_exc) begin
                            compare($sformatf("lane%0d.inst", k), o_fetch_inst[k].inst,
                                    want_inst[k]);
                        end
                        compare($sformatf("lane%0d.ftq_idx", k),
                                32'(o_fetch_inst[k].ftq_idx), 32'(exp_idx));
                        compare($sformatf("lane%0d.ftq_offset", k),
                                32'(o_fetch_inst[k].ftq_offset), 32'(want_off[k]));
                        compare($sformatf("lane%0d.has_except", k),
                                32'(o_fetch_inst[k].has_except), 32'(want_exc));
                    end
                end
                i_read_ftq_idx = exp_idx;
                read_exp       = addr;
                read_pend      = 1'b1;
                rnd = $random(seed);
                commit_idx_q.push_back(exp_idx);
                commit_due_q.push_back(cycle_cnt + 1 + int'(rnd[2:0]));
                if (!addr[0]) begin
                    exp_q.push_back(addr + 32'd16);
                end
                exp_idx++;
                beats_since++;
                beat_total++;
            end
        end
    endtask

    task automatic tick(input logic redir, input logic [31:0] pc);
        @(negedge clk);
        observe();
        i_redirect_vld = redir;
        i_redirect_pc  = pc;
        if (redir) begin
            exp_q.delete();
            exp_q.push_back(pc);
            exp_idx = '0;
            commit_idx_q.delete();
            commit_due_q.delete();
            beats_since = 0;
        end
        rnd             = $random(seed);
        i_backend_stall = stall_en && (rnd[1:0] == 2'b00);
        i_commit_vld    = 1'b0;
        if (commit_en && !redir && commit_idx_q.size() > 0 && commit_due_q[0] <= cycle_cnt) begin
            i_commit_vld     = 1'b1;
            i_commit_ftq_idx = commit_idx_q.pop_front();
            void'(commit_due_q.pop_front());
        end
        // read port output settles after the index change
        if (read_pend) begin
            #1;
            compare("o_read_start_addr", o_read_start_addr, read_exp);
            read_pend = 1'b0;
        end
        cycle_cnt++;
    endtask

    task automatic run_phase(input int cycles, input logic [31:0] pc);
        tick(1'b1, pc);
        repeat (cycles - 1) tick(1'b0, '0);
        // a misaligned start gives exactly one beat
        if (pc[0]) begin
            compare("beats after odd redirect", 32'(beats_since), 32'd1);
        end
    endtask

    initial begin
        clk              = 0;
        rst              = 1;
        seed             = 32'h5d7c_98b9;
        i_redirect_vld   = 0;
        i_redirect_pc    = '0;
        i_backend_stall  = 0;
        i_commit_vld     = 0;
        i_commit_ftq_idx = '0;
        i_read_ftq_idx   = '0;
        i_imem_wr_vld    = 0;
        i_imem_wr_addr   = '0;
        i_imem_wr_data   = '0;
        stall_en         = 0;
        commit_en        = 1;
        exp_idx          = '0;
        beats_since      = 0;
        beat_total       = 0;
        cycle_cnt        = 0;
        timeout_cnt      = 0;
        err_cnt          = 0;
        chk_cnt          = 0;
        read_pend        = 0;
        read_exp         = '0;
        repeat (5) @(negedge clk);
        rst = 0;
        for (int w = 0; w < fetch_pkg::IMEM_WORDS; w++) begin
            @(negedge clk);
            shadow[w]      = $random(seed);
            i_imem_wr_vld  = 1'b1;
            i_imem_wr_addr = fetch_pkg::imem_waddr_t'(w);
            i_imem_wr_data = shadow[w];
        end
        @(negedge clk);
        i_imem_wr_vld = 1'b0;
        stall_en = 1;
        // phase 0 even, phase 1 odd, the rest random
        for (int p = 0; p < PHASES - 2; p++) begin
            rnd = $random(seed);
            run_phase(30 + int'(rnd[20:16]),
                      {rnd[31:1], (p == 1) || (p > 1 && rnd[13:12] == 2'b00)});
        end
        // queue fills and output stops without commits
        stall_en  = 0;
        commit_en = 0;
        rnd = $random(seed);
        run_phase(PHASE_MAX, {rnd[31:1], 1'b0});
        compare("beats with commits withheld", 32'(beats_since), 32'(fetch_pkg::FTQ_DEPTH));
        commit_en = 1;
        repeat (PHASE_MAX) tick(1'b0, '0);
        compare("fetch resumed after commit", 32'(beats_since > fetch_pkg::FTQ_DEPTH), 32'd1);
        $display("checks: %0d  errors: %0d  beats: %0d", chk_cnt, err_cnt, beat_total);
        if (err_cnt == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

// ==== fetcher_properties.sv ====
`timescale 1ns/100ps

module fetcher_properties (
    input logic                                              clk,
    input logic                                              rst,
    input logic                                              i_redirect_vld,
    input logic                                              i_backend_stall,
    input logic [fetch_pkg::SLOT_NUM-1:0]                    o_fetch_vld,
    input fetch_pkg::fetch_entry_t [fetch_pkg::SLOT_NUM-1:0] o_fetch_inst
);

    // output is empty right after a squash
    redirect_clears: assert property (@(posedge clk) disable iff (rst)
        i_redirect_vld |=> o_fetch_vld == '0)
        else $error("output valid after redirect");

    // stall freezes the output register
    stall_holds: assert property (@(posedge clk) disable iff (rst)
        (i_backend_stall && !i_redirect_vld) |=>
            ($stable(o_fetch_vld) && $stable(o_fetch_inst)))
        else $error("output changed during stall");

    // valid lanes packed from lane 0
    lanes_contiguous: assert property (@(posedge clk) disable iff (rst)
        (o_fetch_vld & (o_fetch_vld + 1'b1)) == '0)
        else $error("valid lanes not contiguous");

endmodule

bind fetcher_top fetcher_properties u_fetcher_properties (
    .clk             ( clk             ),
    .rst             ( rst             ),
    .i_redirect_vld  ( i_redirect_vld  ),
    .i_backend_stall ( i_backend_stall ),
    .o_fetch_vld     ( o_fetch_vld     ),
    .o_fetch_inst    ( o_fetch_inst    )
);

// ==== fetcher_top.sv ====
`timescale 1ns/100ps

module fetcher_top (
    input  logic                                            clk,
    input  logic                                            rst,
    input  logic                                            i_redirect_vld,
    input  logic [fetch_pkg::XLEN-1:0]                      i_redirect_pc,
    input  logic                                            i_backend_stall,
    input  logic                                            i_commit_vld,
    input  fetch_pkg::ftq_idx_t                             i_commit_ftq_idx,
    input  fetch_pkg::ftq_idx_t                             i_read_ftq_idx,
    output logic [fetch_pkg::XLEN-1:0]                      o_read_start_addr,
    input  logic                                            i_imem_wr_vld,
    input  fetch_pkg::imem_waddr_t                          i_imem_wr_addr,
    input  logic [fetch_pkg::XLEN-1:0]                      i_imem_wr_data,
    output logic [fetch_pkg::SLOT_NUM-1:0]                  o_fetch_vld,
    output fetch_pkg::fetch_entry_t [fetch_pkg::SLOT_NUM-1:0] o_fetch_inst
);

    ftq_issue_if u_issue_if ();
    icache_if    u_icache_if ();

    fetch_target_queue u_ftq (
        .clk               ( clk               ),
        .rst               ( rst               ),
        .i_redirect_vld    ( i_redirect_vld    ),
        .i_redirect_pc     ( i_redirect_pc     ),
        .i_commit_vld      ( i_commit_vld      ),
        .i_commit_ftq_idx  ( i_commit_ftq_idx  ),
        .i_read_ftq_idx    ( i_read_ftq_idx    ),
        .o_read_start_addr ( o_read_start_addr ),
        .issue             ( u_issue_if.ftq    )
    );

    icache_array u_icache (
        .clk       ( clk               ),
        .rst       ( rst               ),
        .i_wr_vld  ( i_imem_wr_vld     ),
        .i_wr_addr ( i_imem_wr_addr    ),
        .i_wr_data ( i_imem_wr_data    ),
        .port      ( u_icache_if.cache )
    );

    fetch_pipeline u_pipeline (
        .clk             ( clk               ),
        .rst             ( rst               ),
        .i_redirect_vld  ( i_redirect_vld    ),
        .i_backend_stall ( i_backend_stall   ),
        .issue           ( u_issue_if.fetch  ),
        .icache          ( u_icache_if.fetch ),
        .o_fetch_vld     ( o_fetch_vld       ),
        .o_fetch_inst    ( o_fetch_inst      )
    );

endmodule

// ==== fetch_pipeline.sv ====
`timescale 1ns/100ps

module fetch_pipeline (
    input  logic                                            clk,
    input  logic                                            rst,
    input  logic                                            i_redirect_vld,
    input  logic                                            i_backend_stall,
    ftq_issue_if.fetch                                      issue,
    icache_if.fetch                                         icache,
    output logic [fetch_pkg::SLOT_NUM-1:0]                  o_fetch_vld,
    output fetch_pkg::fetch_entry_t [fetch_pkg::SLOT_NUM-1:0] o_fetch_inst
);

    logic                   advance;
    logic                   issue_fire;

    logic                   s1_vld;
    logic                   s1_mis;
    fetch_pkg::ftq_idx_t    s1_idx;
    fetch_pkg::ftq_offset_t s1_offset;

    logic                   s2_vld;
    logic                   s2_mis;
    fetch_pkg::ftq_idx_t    s2_idx;
    fetch_pkg::ftq_offset_t s2_offset;

    fetch_pkg::line_pair_t                            shifted_pair;
    logic [fetch_pkg::SLOT_NUM-1:0]                   start_vld;
    logic [fetch_pkg::SLOT_NUM-1:0]                   cmp_vld;
    fetch_pkg::inst_t [fetch_pkg::SLOT_NUM-1:0]       pd_insts;
    fetch_pkg::inst_t [fetch_pkg::SLOT_NUM-1:0]       cmp_insts;
    fetch_pkg::ftq_offset_t [fetch_pkg::SLOT_NUM-1:0] slot_offs;
    fetch_pkg::ftq_offset_t [fetch_pkg::SLOT_NUM-1:0] cmp_offs;

    // a stall freezes every stage and the array together
    assign advance    = !i_backend_stall;
    assign issue.rdy  = advance;
    assign issue_fire = issue.vld && issue.rdy && !i_redirect_vld;

    // misaligned blocks never touch the array
    assign icache.req       = issue_fire && !issue.misaligned;
    assign icache.line_addr = issue.start_addr[fetch_pkg::XLEN-1:fetch_pkg::OFFSET_W];
    assign icache.hold      = i_backend_stall;

    always_ff @(posedge clk) begin
        if (rst || i_redirect_vld) begin
            s1_vld <= 1'b0;
            s2_vld <= 1'b0;
        end else if (advance) begin
            s1_vld <= issue_fire;
            s2_vld <= s1_vld;
        end
    end

    always_ff @(posedge clk) begin
        if (advance) begin
            s1_idx    <= issue.idx;
            s1_offset <= issue.start_addr[fetch_pkg::OFFSET_W-1:0];
            s1_mis    <= issue.misaligned;
            s2_idx    <= s1_idx;
            s2_offset <= s1_offset;
            s2_mis    <= s1_mis;
        end
    end

    // move block start down to slot 0
    assign shifted_pair = {icache.line1, icache.line0} >> {s2_offset, 3'b000};

    always_comb begin
        for (int k = 0; k < fetch_pkg::SLOT_NUM; k++) begin
            slot_offs[k] = fetch_pkg::ftq_offset_t'(k * fetch_pkg::SLOT_BITS / 8);
        end
    end

    inst_predecode u_predecode (
        .i_line_pair ( shifted_pair ),
        .o_start_vld ( start_vld    ),
        .o_insts     ( pd_insts     )
    );

    slot_compactor #(
        .payload_t ( fetch_pkg::inst_t )
    ) u_inst_compactor (
        .i_vld  ( start_vld ),
        .i_data ( pd_insts  ),
        .o_vld  ( cmp_vld   ),
        .o_data ( cmp_insts )
    );

    // same valid mask, so its o_vld would only repeat cmp_vld
    slot_compactor #(
        .payload_t ( fetch_pkg::ftq_offset_t )
    ) u_offset_compactor (
        .i_vld  ( start_vld ),
        .i_data ( slot_offs ),
        .o_vld  (           ),
        .o_data ( cmp_offs  )
    );

    // result stage
    always_ff @(posedge clk) begin
        if (rst || i_redirect_vld) begin
            o_fetch_vld <= '0;
        end else if (advance) begin
            if (s2_vld && s2_mis) begin
                o_fetch_vld <= fetch_pkg::SLOT_NUM'(1);
            end else if (s2_vld && icache.rsp) begin
                o_fetch_vld <= cmp_vld;
            end else begin
                o_fetch_vld <= '0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (advance) begin
            for (int k = 0; k < fetch_pkg::SLOT_NUM; k++) begin
                o_fetch_inst[k] <= '{
                    inst       : s2_mis ? fetch_pkg::inst_t'(0) : cmp_insts[k],
                    ftq_idx    : s2_idx,
                    ftq_offset : cmp_offs[k],
                    has_except : s2_mis
                };
            end
        end
    end

endmodule

// ==== slot_compactor.sv ====
`timescale 1ns/100ps

module slot_compactor #(
    parameter type payload_t = logic
) (
    input  logic [fetch_pkg::SLOT_NUM-1:0]     i_vld,
    input  payload_t [fetch_pkg::SLOT_NUM-1:0] i_data,
    output logic [fetch_pkg::SLOT_NUM-1:0]     o_vld,
    output payload_t [fetch_pkg::SLOT_NUM-1:0] o_data
);

    // pack valid slots downward keeping their order
    always_comb begin
        int pos;
        pos    = 0;
        o_vld  = '0;
        o_data = '0;
        for (int k = 0; k < fetch_pkg::SLOT_NUM; k++) begin
            if (i_vld[k]) begin
                o_data[pos] = i_data[k];
                o_vld[pos]  = 1'b1;
                pos         = pos + 1;
            end
        end
    end

endmodule

// ==== inst_predecode.sv ====
`timescale 1ns/100ps

module inst_predecode (
    input  fetch_pkg::line_pair_t                         i_line_pair,
    output logic [fetch_pkg::SLOT_NUM-1:0]                o_start_vld,
    output fetch_pkg::inst_t [fetch_pkg::SLOT_NUM-1:0]    o_insts
);

    // slot holds the low half of a 32-bit instruction
    logic [fetch_pkg::SLOT_NUM-1:0] is_rvi;

    always_comb begin
        for (int k = 0; k < fetch_pkg::SLOT_NUM; k++) begin
            // block start is always an instruction boundary
            if (k == 0) begin
                o_start_vld[k] = 1'b1;
            end else begin
                o_start_vld[k] = !is_rvi[k-1];
            end

            // low two bits 11 mark a 32-bit encoding
            is_rvi[k] = o_start_vld[k] &&
                        (i_line_pair[k*fetch_pkg::SLOT_BITS +: 2] == 2'b11);
        end
    end

    // 32 bits from each slot with a don't-care upper half for compressed ones
    always_comb begin
        for (int k = 0; k < fetch_pkg::SLOT_NUM; k++) begin
            o_insts[k] = i_line_pair[k*fetch_pkg::SLOT_BITS +: fetch_pkg::XLEN];
        end
    end

endmodule

// ==== icache_array.sv ====
`timescale 1ns/100ps

module icache_array (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       i_wr_vld,
    input  fetch_pkg::imem_waddr_t     i_wr_addr,
    input  logic [fetch_pkg::XLEN-1:0] i_wr_data,
    icache_if.cache                    port
);

    logic [fetch_pkg::XLEN-1:0] mem [fetch_pkg::IMEM_WORDS];

    logic                   s1_vld;
    fetch_pkg::imem_laddr_t s1_line;
    fetch_pkg::imem_laddr_t s1_next;
    fetch_pkg::line_t       rd_line0;
    fetch_pkg::line_t       rd_line1;

    // successor line wraps with the index width
    assign s1_next = s1_line + 1'b1;

    // load port
    always_ff @(posedge clk) begin
        if (i_wr_vld) begin
            mem[i_wr_addr] <= i_wr_data;
        end
    end

    // word 0 sits in the low bits of a line
    always_comb begin
        for (int w = 0; w < fetch_pkg::LINE_BYTES / (fetch_pkg::XLEN / 8); w++) begin
            rd_line0[w*fetch_pkg::XLEN +: fetch_pkg::XLEN] =
                mem[{s1_line, fetch_pkg::WORD_SEL_W'(w)}];
            rd_line1[w*fetch_pkg::XLEN +: fetch_pkg::XLEN] =
                mem[{s1_next, fetch_pkg::WORD_SEL_W'(w)}];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            s1_vld   <= 1'b0;
            port.rsp <= 1'b0;
        end else if (!port.hold) begin
            s1_vld   <= port.req;
            port.rsp <= s1_vld;
        end
    end

    always_ff @(posedge clk) begin
        if (!port.hold) begin
            s1_line    <= fetch_pkg::imem_laddr_t'(port.line_addr);
            port.line0 <= rd_line0;
            port.line1 <= rd_line1;
        end
    end

endmodule

// ==== fetch_target_queue.sv ====
`timescale 1ns/100ps

module fetch_target_queue (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       i_redirect_vld,
    input  logic [fetch_pkg::XLEN-1:0] i_redirect_pc,
    input  logic                       i_commit_vld,
    input  fetch_pkg::ftq_idx_t        i_commit_ftq_idx,
    input  fetch_pkg::ftq_idx_t        i_read_ftq_idx,
    output logic [fetch_pkg::XLEN-1:0] o_read_start_addr,
    ftq_issue_if.ftq                   issue
);

    logic [fetch_pkg::XLEN-1:0] start_mem [fetch_pkg::FTQ_DEPTH];
    logic [fetch_pkg::XLEN-1:0] next_pc;
    logic                       active;
    fetch_pkg::ftq_ptr_t        alloc_ptr;
    fetch_pkg::ftq_ptr_t        issue_ptr;
    fetch_pkg::ftq_ptr_t        commit_ptr;
    fetch_pkg::ftq_ptr_t        used_cnt;
    fetch_pkg::ftq_idx_t        commit_dist;
    logic                       full;
    logic                       alloc_en;
    logic                       issue_fire;

    assign used_cnt = alloc_ptr - commit_ptr;
    assign full     = used_cnt == fetch_pkg::ftq_ptr_t'(fetch_pkg::FTQ_DEPTH);

    // an odd redirect pc keeps every later block odd, so only its first block is queued
    assign alloc_en = active && !full && !next_pc[0];

    assign issue.vld        = issue_ptr != alloc_ptr;
    assign issue.idx        = fetch_pkg::ftq_idx_t'(issue_ptr);
    assign issue.start_addr = start_mem[issue.idx];
    assign issue.misaligned = issue.start_addr[0];
    assign issue_fire       = issue.vld && issue.rdy;

    // distance from the oldest live entry to the committed one
    assign commit_dist = i_commit_ftq_idx - fetch_pkg::ftq_idx_t'(commit_ptr);

    // backend read port
    assign o_read_start_addr = start_mem[i_read_ftq_idx];

    always_ff @(posedge clk) begin
        if (i_redirect_vld) begin
            start_mem[0] <= i_redirect_pc;
        end else if (alloc_en) begin
            start_mem[fetch_pkg::ftq_idx_t'(alloc_ptr)] <= next_pc;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            active     <= 1'b0;
            next_pc    <= '0;
            alloc_ptr  <= '0;
            issue_ptr  <= '0;
            commit_ptr <= '0;
        end else if (i_redirect_vld) begin
            // redirect block goes straight into entry 0
            active     <= 1'b1;
            next_pc    <= i_redirect_pc + fetch_pkg::XLEN'(fetch_pkg::LINE_BYTES);
            alloc_ptr  <= fetch_pkg::ftq_ptr_t'(1);
            issue_ptr  <= '0;
            commit_ptr <= '0;
        end else begin
            if (alloc_en) begin
                alloc_ptr <= alloc_ptr + 1'b1;
                next_pc   <= next_pc + fetch_pkg::XLEN'(fetch_pkg::LINE_BYTES);
            end
            if (issue_fire) begin
                issue_ptr <= issue_ptr + 1'b1;
            end
            // frees everything up to and including the committed entry
            if (i_commit_vld) begin
                commit_ptr <= commit_ptr + fetch_pkg::ftq_ptr_t'(commit_dist) + 1'b1;
            end
        end
    end

endmodule

// ==== fetch_ifs.sv ====
`timescale 1ns/100ps

// block issue from the queue to the fetch pipeline
interface ftq_issue_if;
    logic                       vld;
    fetch_pkg::ftq_idx_t        idx;
    logic [fetch_pkg::XLEN-1:0] start_addr;
    logic                       misaligned;
    logic                       rdy;

    modport ftq (
        output vld, idx, start_addr, misaligned,
        input  rdy
    );

    modport fetch (
        input  vld, idx, start_addr, misaligned,
        output rdy
    );
endinterface

// line pair read with two advancing cycles of latency
interface icache_if;
    logic                  req;
    fetch_pkg::line_addr_t line_addr;
    logic                  hold;
    logic                  rsp;
    fetch_pkg::line_t      line0;
    fetch_pkg::line_t      line1;

    modport fetch (output req, line_addr, hold, input rsp, line0, line1);
    modport cache (input req, line_addr, hold, output rsp, line0, line1);
endinterface

// ==== fetch_pkg.sv ====
package fetch_pkg;

    // core sizes
    localparam int XLEN       = 32;
    localparam int LINE_BYTES = 16;
    localparam int SLOT_NUM   = 8;
    localparam int FTQ_DEPTH  = 8;
    localparam int IMEM_LINES = 64;

    // derived widths
    localparam int LINE_BITS  = LINE_BYTES * 8;
    localparam int SLOT_BITS  = LINE_BITS / SLOT_NUM;
    localparam int OFFSET_W   = $clog2(LINE_BYTES);
    localparam int WORD_SEL_W = $clog2(LINE_BYTES / (XLEN / 8));
    localparam int LINE_IDX_W = $clog2(IMEM_LINES);
    localparam int FTQ_IDX_W  = $clog2(FTQ_DEPTH);
    localparam int IMEM_WORDS = IMEM_LINES * LINE_BYTES / (XLEN / 8);

    // queue index and a pointer with one extra wrap bit
    typedef logic [FTQ_IDX_W-1:0] ftq_idx_t;
    typedef logic [FTQ_IDX_W:0]   ftq_ptr_t;

    // byte offset of an instruction inside its block
    typedef logic [OFFSET_W-1:0] ftq_offset_t;

    typedef logic [XLEN-1:0] inst_t;

    typedef logic [LINE_BITS-1:0]   line_t;
    typedef logic [2*LINE_BITS-1:0] line_pair_t;

    // line number of a byte address
    typedef logic [XLEN-OFFSET_W-1:0] line_addr_t;

    // array addressing wraps modulo IMEM_LINES
    typedef logic [LINE_IDX_W-1:0]            imem_laddr_t;
    typedef logic [LINE_IDX_W+WORD_SEL_W-1:0] imem_waddr_t;

    // one output lane
    typedef struct packed {
        inst_t       inst;
        ftq_idx_t    ftq_idx;
        ftq_offset_t ftq_offset;
        logic        has_except;
    } fetch_entry_t;

endpackage
